/* motorPwm.f */
+incdir+source
source/motorPkg.sv
source/motorRegs.sv
source/stepTimer.sv
source/pwmGenerator.sv
source/gateMapper.sv
source/motorPwmTop.sv
verif/motorPwm_properties.sv
verif/motorPwmTb.sv

/* verif/motorPwmTb.sv */
`include "motor_defs.svh"

module motorPwmTb;
    import motorPkg::*;

    localparam int TimeoutCycles  = 20000;
    localparam int PeriodLen      = 20;
    localparam int StepLen        = 10;
    localparam int MinWide        = 4;
    localparam int MinCarry       = 11;
    // one commutation cycle is exactly three PWM periods, so nothing restarts a period early
    localparam int CommCycles     = 6 * StepLen;
    localparam int PeriodsPerComm = CommCycles / PeriodLen;

    logic                     clk;
    logic                     rstN;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`MOTOR_ADDR_W-1:0] adr;
    logic [`MOTOR_DATA_W-1:0] datIn;
    logic [`MOTOR_DATA_W-1:0] datOut;
    logic                     ack;
    logic                     pwm;
    gateDriveT                gates;

    int unsigned errCount   = 0;
    int unsigned cycleCount = 0;

    motorPwmTop i_motorPwmTop (
        .clk    (clk),
        .rstN   (rstN),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .datOut (datOut),
        .ack    (ack),
        .pwm    (pwm),
        .gates  (gates)
    );

    bind motorPwmTop motorPwmProperties i_motorPwmProperties (
        .clk   (clk),
        .rstN  (rstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datIn (datIn),
        .ack   (ack),
        .pwm   (pwm),
        .gates (gates)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic reportMismatch(input string what);
        errCount++;
        $display("FAIL %0t: %s", $time, what);
    endtask

    // every call starts and ends 10 time units after a rising edge
    task automatic busCycle(input logic write, input logic [`MOTOR_ADDR_W-1:0] a,
                            input logic [`MOTOR_DATA_W-1:0] d,
                            output logic [`MOTOR_DATA_W-1:0] q);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = a;
        datIn = d;
        do begin
            @(posedge clk);
            #10;
        end while (!ack);
        q   = datOut;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic writeReg(input logic [`MOTOR_ADDR_W-1:0] a, input logic [`MOTOR_DATA_W-1:0] d);
        logic [`MOTOR_DATA_W-1:0] unused;
        busCycle(1'b1, a, d, unused);
    endtask

    task automatic expectRead(input logic [`MOTOR_ADDR_W-1:0] a,
                              input logic [`MOTOR_DATA_W-1:0] want);
        logic [`MOTOR_DATA_W-1:0] got;
        busCycle(1'b0, a, '0, got);
        assert (got == want)
            else reportMismatch($sformatf("address %0d read 0x%08h, expected 0x%08h", a, got, want));
    endtask

    // the two control bits are run and direction
    function automatic logic [`MOTOR_DATA_W-1:0] fieldMask(input logic [`MOTOR_ADDR_W-1:0] a);
        case (a)
            `MOTOR_REG_CTRL:     return 32'h3;
            `MOTOR_REG_PERIOD,
            `MOTOR_REG_MINPULSE: return (32'd1 << `MOTOR_PERIOD_W) - 1;
            `MOTOR_REG_DUTY:     return (32'd1 << `MOTOR_WIDTH_W) - 1;
            `MOTOR_REG_STEPLEN:  return (32'd1 << `MOTOR_STEP_W) - 1;
            default:             return '0;
        endcase
    endfunction

    // forward table as {high phase, low phase} with U on bit 0
    function automatic logic [5:0] phasePair(input int s);
        case (s)
            0:       return {3'b001, 3'b010};
            1:       return {3'b001, 3'b100};
            2:       return {3'b010, 3'b100};
            3:       return {3'b010, 3'b001};
            4:       return {3'b100, 3'b001};
            5:       return {3'b100, 3'b010};
            default: return 6'b000000;
        endcase
    endfunction

    // cycle 0 is the first cycle with run set, gates lag step and pwm by one cycle
    task automatic watchDrive(input int cycles, input logic dir, input int firstHigh,
                              output int highCount);
        int         c;
        int         s;
        logic       pwmPrev;
        logic [5:0] pair;
        gateDriveT  want;
        highCount = 0;
        pwmPrev   = 1'b0;
        for (c = 0; c < cycles; c++) begin
            if (c >= 1) begin
                s             = ((c - 1) / StepLen) % 6;
                pair          = phasePair(s);
                want.highSide = (dir ? pair[2:0] : pair[5:3]) & {3{pwmPrev}};
                want.lowSide  = dir ? pair[5:3] : pair[2:0];
                assert (gates == want)
                    else reportMismatch($sformatf("gates %b, expected %b", gates, want));
            end
            if (c < firstHigh) begin
                assert (!pwm) else reportMismatch($sformatf("pwm high early in cycle %0d", c));
            end else if (c == firstHigh) begin
                assert (pwm) else reportMismatch($sformatf("no first pulse in cycle %0d", c));
            end
            // totals skip the cycleLast cycle that closes the last commutation cycle
            if (c >= cycles - CommCycles && c <= cycles - 2 && pwm) begin
                highCount++;
            end
            pwmPrev = pwm;
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        logic [`MOTOR_ADDR_W-1:0] order [0:4];
        logic [`MOTOR_DATA_W-1:0] value [0:4];
        logic [`MOTOR_ADDR_W-1:0] tmp;
        int                       i;
        int                       j;
        int                       duty;
        int                       k;
        int                       highCount;
        void'($urandom(72));
        clk   = 1'b0;
        rstN  = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datIn = '0;
        repeat (16) @(posedge clk);
        #10;
        rstN = 1'b1;

        // every word reads zero out of reset, the totals included
        for (i = 0; i < 8; i++) begin
            expectRead(i[`MOTOR_ADDR_W-1:0], 32'h0);
        end

        order = '{`MOTOR_REG_CTRL, `MOTOR_REG_PERIOD, `MOTOR_REG_MINPULSE,
                  `MOTOR_REG_DUTY, `MOTOR_REG_STEPLEN};
        for (i = 4; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 5; i++) begin
            value[i] = $urandom;
            if (order[i] == `MOTOR_REG_CTRL) begin
                // the motor stays stopped during the register test
                value[i][0] = 1'b0;
            end
            writeReg(order[i], value[i]);
        end
        writeReg(3'd6, $urandom);
        writeReg(3'd7, $urandom);
        for (i = 0; i < 5; i++) begin
            expectRead(order[i], value[i] & fieldMask(order[i]));
        end
        expectRead(3'd6, 32'h0);
        expectRead(3'd7, 32'h0);

        // forward rotation, every request at least the minimum pulse
        duty = 4 + $urandom % 15;
        writeReg(`MOTOR_REG_PERIOD, PeriodLen);
        writeReg(`MOTOR_REG_MINPULSE, MinWide);
        writeReg(`MOTOR_REG_DUTY, duty);
        writeReg(`MOTOR_REG_STEPLEN, StepLen);
        writeReg(`MOTOR_REG_CTRL, 32'h1);
        watchDrive(2 * CommCycles, 1'b0, PeriodLen + 1, highCount);
        expectRead(`MOTOR_REG_TOTALS, {16'(PeriodsPerComm * duty), 16'(highCount)});
        writeReg(`MOTOR_REG_CTRL, 32'h0);

        // reverse rotation, short requests wait for k periods
        duty = 2 + $urandom % 4;
        k    = (MinCarry + duty - 1) / duty;
        writeReg(`MOTOR_REG_MINPULSE, MinCarry);
        writeReg(`MOTOR_REG_DUTY, duty);
        writeReg(`MOTOR_REG_CTRL, 32'h3);
        watchDrive(3 * CommCycles, 1'b1, k * PeriodLen + 1, highCount);
        expectRead(`MOTOR_REG_TOTALS, {16'(PeriodsPerComm * duty), 16'(highCount)});
        writeReg(`MOTOR_REG_CTRL, 32'h0);
        repeat (4) @(posedge clk);
        #10;

        $display("closing: %0d bus check errors, %0d assertion failures", errCount,
                 i_motorPwmTop.i_motorPwmProperties.failCount);
        if (errCount == 0 && i_motorPwmTop.i_motorPwmProperties.failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verif/motorPwm_properties.sv */
`include "motor_defs.svh"

module motorPwmProperties (
    input logic                     clk,
    input logic                     rstN,
    input logic                     cyc,
    input logic                     stb,
    input logic                     we,
    input logic [`MOTOR_ADDR_W-1:0] adr,
    input logic [`MOTOR_DATA_W-1:0] datIn,
    input logic                     ack,
    input logic                     pwm,
    input motorPkg::gateDriveT      gates
);
    int unsigned failCount = 0;

    logic                       newWrite;
    logic                       runM;
    logic [`MOTOR_PERIOD_W-1:0] minPulseM;
    logic [`MOTOR_WIDTH_W-1:0]  minWide;
    logic [`MOTOR_WIDTH_W-1:0]  dutyM;
    logic [`MOTOR_WIDTH_W-1:0]  highRun;
    logic [`MOTOR_WIDTH_W-1:0]  expWidth;

    // a request still held in its ack cycle belongs to the access being acked
    assign newWrite = cyc & stb & we & ~ack;
    assign minWide  = {{(`MOTOR_WIDTH_W-`MOTOR_PERIOD_W){1'b0}}, minPulseM};

    // copy of the pulse settings as seen on the bus
    always_ff @(posedge clk) begin
        if (!rstN) begin
            runM      <= 1'b0;
            minPulseM <= '0;
            dutyM     <= '0;
        end else if (newWrite) begin
            case (adr)
                `MOTOR_REG_CTRL:     runM      <= datIn[0];
                `MOTOR_REG_MINPULSE: minPulseM <= datIn[`MOTOR_PERIOD_W-1:0];
                `MOTOR_REG_DUTY:     dutyM     <= datIn[`MOTOR_WIDTH_W-1:0];
                default: ;
            endcase
        end
    end

    // short requests add up over whole periods until the sum reaches the minimum
    always_comb begin
        if (dutyM == '0) begin
            expWidth = '0;
        end else if (dutyM >= minWide) begin
            expWidth = dutyM;
        end else begin
            expWidth = ((minWide + dutyM - 1'b1) / dutyM) * dutyM;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || !pwm) begin
            highRun <= '0;
        end else begin
            highRun <= highRun + 1'b1;
        end
    end

    resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> !ack && !pwm && gates == '0)
        else begin
            failCount++;
            $error("ack, pwm or a gate was high right after reset");
        end

    ackOneCycle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
        else begin
            failCount++;
            $error("ack stayed high for more than one cycle");
        end

    ackRequested: assert property (@(posedge clk) disable iff (!rstN) ack |-> $past(cyc && stb))
        else begin
            failCount++;
            $error("ack came without a bus request");
        end

    pulseWidth: assert property (@(posedge clk) disable iff (!rstN)
            runM && $fell(pwm) |-> highRun == expWidth)
        else begin
            failCount++;
            $error("pwm pulse lasted %0d cycles, expected %0d", $sampled(highRun), expWidth);
        end

    noShootThrough: assert property (@(posedge clk) disable iff (!rstN)
            (gates.highSide & gates.lowSide) == 3'b000)
        else begin
            failCount++;
            $error("a phase had both of its gates on");
        end

    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
            !runM && !$past(runM) |-> !pwm && gates == '0)
        else begin
            failCount++;
            $error("pwm or a gate was high while the motor was stopped");
        end

endmodule

/* source/motorPwmTop.sv */
`include "motor_defs.svh"

module motorPwmTop (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`MOTOR_ADDR_W-1:0]   adr,
    input  logic [`MOTOR_DATA_W-1:0]   datIn,
    output logic [`MOTOR_DATA_W-1:0]   datOut,
    output logic                       ack,
    output logic                       pwm,
    output motorPkg::gateDriveT        gates
);
    import motorPkg::*;

    pwmConfigT   pwmCfg;
    driveConfigT driveCfg;
    stepInfoT    stepInfo;
    pulseTotalsT totals;

    motorRegs i_motorRegs (
        .clk       (clk),
        .rstN      (rstN),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .datIn     (datIn),
        .datOut    (datOut),
        .ack       (ack),
        .totals    (totals),
        .cycleLast (stepInfo.cycleLast),
        .pwmCfg    (pwmCfg),
        .driveCfg  (driveCfg)
    );

    stepTimer i_stepTimer (
        .clk      (clk),
        .rstN     (rstN),
        .driveCfg (driveCfg),
        .step     (stepInfo)
    );

    pwmGenerator i_pwmGenerator (
        .clk    (clk),
        .rstN   (rstN),
        .pwmCfg (pwmCfg),
        .run    (driveCfg.run),
        .step   (stepInfo),
        .pwm    (pwm),
        .totals (totals)
    );

    gateMapper i_gateMapper (
        .clk       (clk),
        .rstN      (rstN),
        .step      (stepInfo),
        .run       (driveCfg.run),
        .direction (driveCfg.direction),
        .pwm       (pwm),
        .gates     (gates)
    );

endmodule

/* source/gateMapper.sv */
module gateMapper (
    input  logic                clk,
    input  logic                rstN,
    input  motorPkg::stepInfoT  step,
    input  logic                run,
    input  logic                direction,
    input  logic                pwm,
    output motorPkg::gateDriveT gates
);
    import motorPkg::*;

    localparam logic [2:0] PhaseU = 3'b001;
    localparam logic [2:0] PhaseV = 3'b010;
    localparam logic [2:0] PhaseW = 3'b100;

    logic [2:0] fwdHi;
    logic [2:0] fwdLo;
    logic [2:0] hiPhase;
    logic [2:0] loPhase;
    gateDriveT  gatesNext;

    // forward six-step table, high phase first
    always_comb begin
        case (step.stepIdx)
            3'd0:    {fwdHi, fwdLo} = {PhaseU, PhaseV};
            3'd1:    {fwdHi, fwdLo} = {PhaseU, PhaseW};
            3'd2:    {fwdHi, fwdLo} = {PhaseV, PhaseW};
            3'd3:    {fwdHi, fwdLo} = {PhaseV, PhaseU};
            3'd4:    {fwdHi, fwdLo} = {PhaseW, PhaseU};
            3'd5:    {fwdHi, fwdLo} = {PhaseW, PhaseV};
            default: {fwdHi, fwdLo} = {3'b000, 3'b000};
        endcase
    end

    always_comb begin
        // reverse rotation drives the same pair with the roles swapped
        hiPhase = direction ? fwdLo : fwdHi;
        loPhase = direction ? fwdHi : fwdLo;

        // high side is chopped, low side stays on for the whole step
        gatesNext.highSide = run ? (hiPhase & {3{pwm}}) : 3'b000;
        gatesNext.lowSide  = run ? loPhase : 3'b000;
    end

    // high and low phases always differ, so no leg ever shoots through
    always_ff @(posedge clk) begin
        if (!rstN) begin
            gates <= '0;
        end else begin
            gates <= gatesNext;
        end
    end

endmodule

/* source/pwmGenerator.sv */
`include "motor_defs.svh"

module pwmGenerator (
    input  logic                  clk,
    input  logic                  rstN,
    input  motorPkg::pwmConfigT   pwmCfg,
    input  logic                  run,
    input  motorPkg::stepInfoT    step,
    output logic                  pwm,
    output motorPkg::pulseTotalsT totals
);
    import motorPkg::*;

    logic [`MOTOR_WIDTH_W-1:0]  effWidth;
    logic [`MOTOR_PERIOD_W-1:0] periodCnt;
    logic                       reload;
    logic                       reloadQ;
    logic                       periodEnd;
    logic [`MOTOR_WIDTH_W-1:0]  carry;
    logic [`MOTOR_WIDTH_W-1:0]  pulseSum;
    logic [`MOTOR_WIDTH_W-1:0]  minPulseExt;
    logic                       belowMin;
    logic [`MOTOR_WIDTH_W-1:0]  pulseCnt;
    pulseTotalsT                acc;

    assign effWidth = run ? pwmCfg.dutyLen : '0;

    // period restarts on its last count, on the commutation wrap, or while idle
    assign reload = step.cycleLast | (periodCnt == 12'd1) | (effWidth == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            periodCnt <= '0;
        end else if (reload) begin
            periodCnt <= pwmCfg.periodLen;
        end else begin
            periodCnt <= periodCnt - 1'b1;
        end
    end

    // only the first reload of a run of reloads counts as a period end
    always_ff @(posedge clk) begin
        if (!rstN) begin
            reloadQ   <= 1'b0;
            periodEnd <= 1'b0;
        end else begin
            reloadQ   <= reload;
            periodEnd <= reload & ~reloadQ;
        end
    end

    assign minPulseExt = {{(`MOTOR_WIDTH_W-`MOTOR_PERIOD_W){1'b0}}, pwmCfg.minPulse};
    assign pulseSum    = carry + effWidth;
    assign belowMin    = pulseSum < minPulseExt;

    // short requests pile up in carry until they are wide enough to drive a MOSFET
    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            carry    <= '0;
            pulseCnt <= '0;
        end else if (periodEnd) begin
            if (belowMin) begin
                carry    <= pulseSum;
                pulseCnt <= '0;
            end else begin
                carry    <= '0;
                pulseCnt <= pulseSum;
            end
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    assign pwm = run & (pulseCnt != '0);

    // the gap between wantTotal and realTotal is what the minimum rule held back
    always_ff @(posedge clk) begin
        if (!rstN || step.cycleLast) begin
            acc <= '0;
        end else begin
            if (periodEnd) begin
                acc.wantTotal <= acc.wantTotal + effWidth;
            end
            if (pwm) begin
                acc.realTotal <= acc.realTotal + 1'b1;
            end
        end
    end

    assign totals = acc;

endmodule

/* source/stepTimer.sv */
`include "motor_defs.svh"

module stepTimer (
    input  logic                  clk,
    input  logic                  rstN,
    input  motorPkg::driveConfigT driveCfg,
    output motorPkg::stepInfoT    step
);
    import motorPkg::*;

    logic [`MOTOR_STEP_W-1:0] cycleCnt;
    logic [2:0]               stepIdx;
    logic                     stepEnd;
    stepInfoT                 stepNow;

    // one extra bit keeps the compare clean at the top of the range,
    // and a stepLen of zero behaves like a stepLen of one
    assign stepEnd = ({1'b0, cycleCnt} + 1'b1) >= {1'b0, driveCfg.stepLen};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cycleCnt <= '0;
            stepIdx  <= 3'd0;
        end else if (!driveCfg.run) begin
            // stopped motor parks on step 0 with a fresh count
            cycleCnt <= '0;
            stepIdx  <= 3'd0;
        end else if (stepEnd) begin
            cycleCnt <= '0;
            if (stepIdx == 3'd5) begin
                stepIdx <= 3'd0;
            end else begin
                stepIdx <= stepIdx + 3'd1;
            end
        end else begin
            cycleCnt <= cycleCnt + 1'b1;
        end
    end

    // cycleLast is the final clock of step 5, the wrap of the six-step cycle
    always_comb begin
        stepNow.stepIdx   = stepIdx;
        stepNow.cycleLast = driveCfg.run & stepEnd & (stepIdx == 3'd5);
    end

    assign step = stepNow;

endmodule

/* source/motorRegs.sv */
`include "motor_defs.svh"

module motorRegs (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`MOTOR_ADDR_W-1:0]   adr,
    input  logic [`MOTOR_DATA_W-1:0]   datIn,
    output logic [`MOTOR_DATA_W-1:0]   datOut,
    output logic                       ack,
    input  motorPkg::pulseTotalsT      totals,
    input  logic                       cycleLast,
    output motorPkg::pwmConfigT        pwmCfg,
    output motorPkg::driveConfigT      driveCfg
);
    import motorPkg::*;

    pulseTotalsT              totalsQ;
    logic                     request;
    logic [`MOTOR_DATA_W-1:0] readMux;

    // the master holds its request through the ack cycle, so mask it there
    assign request = cyc & stb & ~ack;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= request;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pwmCfg   <= '0;
            driveCfg <= '0;
        end else if (request && we) begin
            case (adr)
                `MOTOR_REG_CTRL: begin
                    driveCfg.run       <= datIn[0];
                    driveCfg.direction <= datIn[1];
                end
                `MOTOR_REG_PERIOD:   pwmCfg.periodLen <= datIn[`MOTOR_PERIOD_W-1:0];
                `MOTOR_REG_MINPULSE: pwmCfg.minPulse  <= datIn[`MOTOR_PERIOD_W-1:0];
                `MOTOR_REG_DUTY:     pwmCfg.dutyLen   <= datIn[`MOTOR_WIDTH_W-1:0];
                `MOTOR_REG_STEPLEN:  driveCfg.stepLen <= datIn[`MOTOR_STEP_W-1:0];
                default: ;
            endcase
        end
    end

    // snapshot of the totals of the commutation cycle that just ended
    always_ff @(posedge clk) begin
        if (!rstN) begin
            totalsQ <= '0;
        end else if (cycleLast) begin
            totalsQ <= totals;
        end
    end

    always_comb begin
        readMux = '0;
        case (adr)
            `MOTOR_REG_CTRL: begin
                readMux[0] = driveCfg.run;
                readMux[1] = driveCfg.direction;
            end
            `MOTOR_REG_PERIOD:   readMux[`MOTOR_PERIOD_W-1:0] = pwmCfg.periodLen;
            `MOTOR_REG_MINPULSE: readMux[`MOTOR_PERIOD_W-1:0] = pwmCfg.minPulse;
            `MOTOR_REG_DUTY:     readMux[`MOTOR_WIDTH_W-1:0]  = pwmCfg.dutyLen;
            `MOTOR_REG_STEPLEN:  readMux[`MOTOR_STEP_W-1:0]   = driveCfg.stepLen;
            `MOTOR_REG_TOTALS:   readMux = {totalsQ.wantTotal, totalsQ.realTotal};
            default:             readMux = '0;
        endcase
    end

    // read data is captured with the edge that raises ack
    always_ff @(posedge clk) begin
        if (request) begin
            datOut <= readMux;
        end
    end

endmodule

/* source/motorPkg.sv */
`include "motor_defs.svh"

package motorPkg;

    // PWM timing, all values in clock cycles
    typedef struct packed {
        logic [`MOTOR_PERIOD_W-1:0] periodLen;
        logic [`MOTOR_PERIOD_W-1:0] minPulse;
        logic [`MOTOR_WIDTH_W-1:0]  dutyLen;
    } pwmConfigT;

    // direction 0 runs the forward step table, 1 runs it reversed
    typedef struct packed {
        logic                     run;
        logic                     direction;
        logic [`MOTOR_STEP_W-1:0] stepLen;
    } driveConfigT;

    // stepIdx runs 0 to 5, cycleLast marks the final cycle of step 5
    typedef struct packed {
        logic [2:0] stepIdx;
        logic       cycleLast;
    } stepInfoT;

    typedef struct packed {
        logic [`MOTOR_WIDTH_W-1:0] wantTotal;
        logic [`MOTOR_WIDTH_W-1:0] realTotal;
    } pulseTotalsT;

    // bit 0 is phase U, bit 1 is V, bit 2 is W
    typedef struct packed {
        logic [2:0] highSide;
        logic [2:0] lowSide;
    } gateDriveT;

endpackage

/* source/motor_defs.svh */
`ifndef MOTOR_DEFS_SVH
`define MOTOR_DEFS_SVH

// Wishbone word address and data widths
`define MOTOR_ADDR_W        3
`define MOTOR_DATA_W        32

// register map, word addresses
`define MOTOR_REG_CTRL      3'd0
`define MOTOR_REG_PERIOD    3'd1
`define MOTOR_REG_MINPULSE  3'd2
`define MOTOR_REG_DUTY      3'd3
`define MOTOR_REG_STEPLEN   3'd4
`define MOTOR_REG_TOTALS    3'd5

// counter widths
`define MOTOR_PERIOD_W      12
`define MOTOR_WIDTH_W       16
`define MOTOR_STEP_W        24

`endif
